// ==== dv/panda_ctrl_tb.sv ====
module panda_ctrl_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic clk_i = 1'b0;
   logic rst_ni, clear_i, start_i, reg_we_i, engine_done_i;
   logic a_ready_start_i, b_ready_start_i, c_ready_start_i, a_valid_i, b_valid_i, c_valid_i;
   panda_ctrl_pkg::param_addr_t reg_addr_i;
   panda_ctrl_pkg::word_t       reg_wdata_i;
   panda_ctrl_pkg::layer_mode_t mode_i;
   logic a_req_start_o, b_req_start_o, c_req_start_o, stream_ready_o, out_stream_ready_o;
   logic engine_clear_o, engine_enable_o, engine_start_o, done_o;
   panda_ctrl_pkg::word_t a_base_addr_o, b_base_addr_o, c_base_addr_o;
   panda_ctrl_pkg::word_t trans_size_o, out_trans_size_o;
   panda_ctrl_pkg::mem_sel_t mem_sel_o;

   panda_ctrl_pkg::word_t    regs [panda_ctrl_pkg::ParamCount]; // Register mirror
   panda_ctrl_pkg::word_t    beats [8];                          // Load beats per mem_sel
   panda_ctrl_pkg::word_t    out_beats, load_total, exp_total;
   panda_ctrl_pkg::mem_sel_t last_sel;                           // Last memory written
   int     starts, dones;
   logic   quiet;            // Between done or clear and the next start
   integer seed = 32'hf4d8;

   panda_ctrl_top dut_i (.*);

   always #2 clk_i = ~clk_i; // 4 ns period

   task automatic fail_now();
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_word(string name, panda_ctrl_pkg::word_t got,
                             panda_ctrl_pkg::word_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         fail_now();
      end
   endtask

   task automatic check_sel(string name, panda_ctrl_pkg::mem_sel_t got,
                            panda_ctrl_pkg::mem_sel_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         fail_now();
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         fail_now();
      end
   endtask

   function automatic int unsigned rand_below(int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Beats a memory should receive under the current mode
   function automatic panda_ctrl_pkg::word_t expected_beats(int sel);
      if (sel == panda_ctrl_pkg::sel_wconv && mode_i != panda_ctrl_pkg::mode_cnn) return '0;
      if (sel == panda_ctrl_pkg::sel_wfc && mode_i == panda_ctrl_pkg::mode_none) return '0;
      return regs[(sel - 1) * 3]; // Three registers per memory, count first
   endfunction

   task automatic drive_random();
      a_valid_i       = rand_below(4) != 0;
      b_valid_i       = rand_below(4) != 0;
      c_valid_i       = rand_below(2) != 0;
      a_ready_start_i = rand_below(4) != 0;
      b_ready_start_i = rand_below(4) != 0;
      c_ready_start_i = rand_below(4) != 0;
      // Engine may finish only once the sink took every beat
      engine_done_i   = (out_beats == regs[panda_ctrl_pkg::OutN]) && (rand_below(2) != 0);
   endtask

   always @(posedge clk_i) begin : monitor
      int idx;
      if (rst_ni && !clear_i) begin
         if (quiet) begin // Nothing may move while idle
            check_bit("a_req_start_o", a_req_start_o, 1'b0);
            check_bit("b_req_start_o", b_req_start_o, 1'b0);
            check_bit("c_req_start_o", c_req_start_o, 1'b0);
            check_bit("stream_ready_o", stream_ready_o, 1'b0);
            check_bit("out_stream_ready_o", out_stream_ready_o, 1'b0);
         end
         if (mem_sel_o != panda_ctrl_pkg::sel_null) begin
            idx = (int'(mem_sel_o) - 1) * 3;
            check_word("trans_size_o", trans_size_o, regs[idx]);
            check_word("a_base_addr_o", a_base_addr_o, regs[idx + 1]);
            check_word("b_base_addr_o", b_base_addr_o, regs[idx + 2]);
         end
         if (stream_ready_o) begin
            check_bit("a_valid_i & b_valid_i", a_valid_i && b_valid_i, 1'b1);
            if (mem_sel_o == panda_ctrl_pkg::sel_null || mem_sel_o < last_sel) begin
               $display("load beat for memory %0d out of order after %0d", mem_sel_o, last_sel);
               fail_now();
            end
            last_sel = mem_sel_o;
            beats[mem_sel_o] = beats[mem_sel_o] + 1;
            load_total = load_total + 1;
         end
         if (out_stream_ready_o) begin
            check_bit("c_valid_i", c_valid_i, 1'b1);
            check_word("c_base_addr_o", c_base_addr_o, regs[panda_ctrl_pkg::OutAddr]);
            out_beats = out_beats + 1;
         end
         if (engine_start_o) begin
            check_word("load beats at engine_start_o", load_total, exp_total);
            check_word("out_trans_size_o", out_trans_size_o, regs[panda_ctrl_pkg::OutN]);
            starts++;
         end
         if (done_o) begin
            check_word("out_stream_ready_o beats at done_o", out_beats,
                       regs[panda_ctrl_pkg::OutN]);
            dones++;
            quiet = 1'b1;
         end
         if (start_i) quiet = 1'b0;
      end
   end

   task automatic run_job(bit abort);
      int cycles;
      int stop_at;
      for (int i = 0; i < panda_ctrl_pkg::ParamCount; i++) begin
         reg_we_i    = 1'b1;
         reg_addr_i  = panda_ctrl_pkg::param_addr_t'(i);
         reg_wdata_i = (i % 3 == 0) ? rand_below(7) : $random(seed); // Counts incl OutN
         regs[i]     = reg_wdata_i;
         @(negedge clk_i);
      end
      reg_we_i = 1'b0;
      mode_i   = panda_ctrl_pkg::layer_mode_t'(rand_below(3));
      for (int s = 0; s < 8; s++) beats[s] = '0;
      {out_beats, load_total, exp_total} = '0;
      last_sel = panda_ctrl_pkg::sel_null;
      starts   = 0;
      dones    = 0;
      for (int s = 1; s < 8; s++) exp_total = exp_total + expected_beats(s);
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      stop_at = abort ? 4 + rand_below(30) : -1;
      cycles  = 0;
      while (dones == 0 && cycles != stop_at && cycles < 4000) begin
         drive_random();
         @(negedge clk_i);
         cycles++;
      end
      if (cycles >= 4000) begin
         $display("timeout: done_o never pulsed within 4000 cycles");
         fail_now();
      end
      if (abort) begin
         clear_i = 1'b1;
         @(negedge clk_i);
         clear_i = 1'b0;
         quiet   = 1'b1;
         check_bit("engine_clear_o", engine_clear_o, 1'b1); // Back in idle
      end
      repeat (5) begin // Idle gap, quiet checks in the monitor
         drive_random();
         @(negedge clk_i);
      end
      if (!abort) begin
         for (int s = 1; s < 8; s++) begin
            check_word($sformatf("beats for mem_sel_o %0d", s), beats[s], expected_beats(s));
         end
         check_word("engine_start_o pulses", starts, 1);
         check_word("done_o pulses", dones, 1);
      end
   endtask

   initial begin
      {rst_ni, clear_i, start_i, reg_we_i, engine_done_i} = '0;
      {a_ready_start_i, b_ready_start_i, c_ready_start_i} = '0;
      {a_valid_i, b_valid_i, c_valid_i} = '0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      mode_i      = panda_ctrl_pkg::mode_fc;
      quiet       = 1'b1;
      for (int i = 0; i < panda_ctrl_pkg::ParamCount; i++) regs[i] = '0;
      repeat (2) @(negedge clk_i);
      check_bit("engine_clear_o", engine_clear_o, 1'b1);
      check_bit("engine_enable_o", engine_enable_o, 1'b0);
      check_bit("engine_start_o", engine_start_o, 1'b0);
      check_bit("done_o", done_o, 1'b0);
      check_sel("mem_sel_o", mem_sel_o, panda_ctrl_pkg::sel_null);
      rst_ni = 1'b1;
      @(negedge clk_i);
      run_job(1'b0);
      run_job(1'b0);
      run_job(1'b0);
      run_job(1'b1); // Aborted by clear_i
      run_job(1'b0);
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== panda_ctrl_top.f ====
src/panda_ctrl_pkg.sv
src/panda_param_regs.sv
src/panda_stream_cfg.sv
src/panda_packet_counter.sv
src/panda_phase_fsm.sv
src/panda_ctrl_top.sv
dv/panda_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f panda_ctrl_top.f \
   --top-module panda_ctrl_tb -o panda_ctrl_sim \
   && ./obj_dir/panda_ctrl_sim | grep -x "PASS: all tests" \
   || exit 1

// ==== src/panda_ctrl_pkg.sv ====
package panda_ctrl_pkg;

   typedef logic [31:0] word_t;       // Sizes, bases, register data
   typedef logic [4:0]  param_addr_t; // Register index

   // Register map, three entries per memory then the output pair
   localparam int unsigned ParamCount = 23;

   localparam int unsigned CfgN        = 0;
   localparam int unsigned CfgAAddr    = 1;
   localparam int unsigned CfgDAddr    = 2;
   localparam int unsigned InstrN      = 3;
   localparam int unsigned InstrAAddr  = 4;
   localparam int unsigned InstrDAddr  = 5;
   localparam int unsigned LutN        = 6;
   localparam int unsigned LutAAddr    = 7;
   localparam int unsigned LutDAddr    = 8;
   localparam int unsigned SparseN     = 9;
   localparam int unsigned SparseAAddr = 10;
   localparam int unsigned SparseDAddr = 11;
   localparam int unsigned ActN        = 12;
   localparam int unsigned ActAAddr    = 13;
   localparam int unsigned ActDAddr    = 14;
   localparam int unsigned WConvN      = 15;
   localparam int unsigned WConvAAddr  = 16;
   localparam int unsigned WConvDAddr  = 17;
   localparam int unsigned WFcN        = 18;
   localparam int unsigned WFcAAddr    = 19;
   localparam int unsigned WFcDAddr    = 20;
   localparam int unsigned OutN        = 21; // Output beat count
   localparam int unsigned OutAddr     = 22; // Output sink base

   // Destination memory of the write enable
   typedef enum logic [2:0] {
      sel_null,
      sel_config,
      sel_instr,
      sel_lut,
      sel_sparse,
      sel_act,
      sel_wconv,
      sel_wfc
   } mem_sel_t;

   typedef enum logic [1:0] {
      mode_fc   = 2'd0, // FC weights only
      mode_cnn  = 2'd1, // Conv then FC weights
      mode_none = 2'd2  // No weight load
   } layer_mode_t;

   typedef enum logic [3:0] {
      idle,
      load_config,
      load_instr,
      load_lut,
      load_sparse,
      load_act,
      load_wconv,
      load_wfc,
      accel_run,
      accel_running,
      terminate
   } phase_t;

endpackage

// ==== src/panda_ctrl_top.sv ====
module panda_ctrl_top (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        clear_i,
   input  logic                        start_i,
   input  logic                        reg_we_i,
   input  panda_ctrl_pkg::param_addr_t reg_addr_i,
   input  panda_ctrl_pkg::word_t       reg_wdata_i,
   input  panda_ctrl_pkg::layer_mode_t mode_i,
   input  logic                        a_ready_start_i,
   input  logic                        b_ready_start_i,
   input  logic                        c_ready_start_i,
   input  logic                        a_valid_i,
   input  logic                        b_valid_i,
   input  logic                        c_valid_i,
   input  logic                        engine_done_i,
   output logic                        a_req_start_o,
   output logic                        b_req_start_o,
   output logic                        c_req_start_o,
   output panda_ctrl_pkg::word_t       a_base_addr_o,
   output panda_ctrl_pkg::word_t       b_base_addr_o,
   output panda_ctrl_pkg::word_t       c_base_addr_o,
   output panda_ctrl_pkg::word_t       trans_size_o,
   output panda_ctrl_pkg::word_t       out_trans_size_o,
   output panda_ctrl_pkg::mem_sel_t    mem_sel_o,
   output logic                        stream_ready_o,
   output logic                        out_stream_ready_o,
   output logic                        engine_clear_o,
   output logic                        engine_enable_o,
   output logic                        engine_start_o,
   output logic                        done_o
);

   panda_ctrl_pkg::word_t  params [panda_ctrl_pkg::ParamCount];
   panda_ctrl_pkg::phase_t phase;
   logic load_clear, load_ready, load_done; // Memory load counter
   logic out_clear, out_ready, out_done;    // Output sink counter

   panda_param_regs param_regs_i (
      .clk_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i,
      .params_o (params)
   );

   panda_stream_cfg stream_cfg_i (
      .phase_i  (phase),
      .params_i (params),
      .trans_size_o, .a_base_addr_o, .b_base_addr_o, .c_base_addr_o,
      .out_size_o (out_trans_size_o),
      .mem_sel_o
   );

   // Load beats need both address and data
   panda_packet_counter load_cnt_i (
      .clk_i, .rst_ni, .clear_i,
      .clear_req_i (load_clear),
      .valid_i     (a_valid_i && b_valid_i),
      .size_i      (trans_size_o),
      .ready_o     (load_ready),
      .done_o      (load_done)
   );

   panda_packet_counter out_cnt_i (
      .clk_i, .rst_ni, .clear_i,
      .clear_req_i (out_clear),
      .valid_i     (c_valid_i),
      .size_i      (out_trans_size_o),
      .ready_o     (out_ready),
      .done_o      (out_done)
   );

   panda_phase_fsm phase_fsm_i (
      .clk_i, .rst_ni, .clear_i, .start_i, .mode_i,
      .a_ready_start_i, .b_ready_start_i, .c_ready_start_i,
      .load_ready_i (load_ready),
      .load_done_i  (load_done),
      .out_ready_i  (out_ready),
      .out_done_i   (out_done),
      .engine_done_i,
      .phase_o      (phase),
      .load_clear_o (load_clear),
      .out_clear_o  (out_clear),
      .stream_ready_o, .out_stream_ready_o,
      .a_req_start_o, .b_req_start_o, .c_req_start_o,
      .engine_clear_o, .engine_enable_o, .engine_start_o, .done_o
   );

endmodule

// ==== src/panda_packet_counter.sv ====
module panda_packet_counter (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  clear_i,     // Abort, empties the counter
   input  logic                  clear_req_i, // Sequencer wants a clear
   input  logic                  valid_i,
   input  panda_ctrl_pkg::word_t size_i,
   output logic                  ready_o,     // Accept strobe
   output logic                  done_o
);

   panda_ctrl_pkg::word_t cnt_q;
   logic                  clr_q; // Clear request, one cycle late

   assign ready_o = valid_i && !clr_q && (cnt_q < size_i);
   assign done_o  = !clr_q && (cnt_q == size_i);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_q <= '0;
         clr_q <= 1'b1; // Hold off until a phase opens
      end else if (clear_i) begin
         cnt_q <= '0;
         clr_q <= 1'b1;
      end else begin
         clr_q <= clear_req_i;
         if (clr_q) cnt_q <= '0;
         else if (ready_o) cnt_q <= cnt_q + 1'b1; // One beat per accept
      end
   end

   // Size of the current phase is never overrun once counting
   a_no_overrun : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !clr_q |-> cnt_q <= size_i
   );

endmodule

// ==== src/panda_param_regs.sv ====
module panda_param_regs (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        reg_we_i,
   input  panda_ctrl_pkg::param_addr_t reg_addr_i,
   input  panda_ctrl_pkg::word_t       reg_wdata_i,
   output panda_ctrl_pkg::word_t       params_o [panda_ctrl_pkg::ParamCount]
);

   panda_ctrl_pkg::word_t params_q [panda_ctrl_pkg::ParamCount];
   logic                  addr_ok;

   // Indices 23..31 fall outside the map
   assign addr_ok = (reg_addr_i < panda_ctrl_pkg::ParamCount);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         for (int i = 0; i < panda_ctrl_pkg::ParamCount; i++) begin
            params_q[i] <= '0; // Sizes of zero skip every phase
         end
      end else if (reg_we_i && addr_ok) begin
         params_q[reg_addr_i] <= reg_wdata_i; // Single-cycle write
      end
   end

   assign params_o = params_q;

   // Software must only write inside the register map
   a_write_in_map : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      reg_we_i |-> addr_ok
   );

endmodule

// ==== src/panda_phase_fsm.sv ====
module panda_phase_fsm (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        clear_i,
   input  logic                        start_i,
   input  panda_ctrl_pkg::layer_mode_t mode_i,
   input  logic                        a_ready_start_i,
   input  logic                        b_ready_start_i,
   input  logic                        c_ready_start_i,
   input  logic                        load_ready_i,
   input  logic                        load_done_i,
   input  logic                        out_ready_i,
   input  logic                        out_done_i,
   input  logic                        engine_done_i,
   output panda_ctrl_pkg::phase_t      phase_o,
   output logic                        load_clear_o,
   output logic                        out_clear_o,
   output logic                        stream_ready_o,
   output logic                        out_stream_ready_o,
   output logic                        a_req_start_o,
   output logic                        b_req_start_o,
   output logic                        c_req_start_o,
   output logic                        engine_clear_o,
   output logic                        engine_enable_o,
   output logic                        engine_start_o,
   output logic                        done_o
);

   panda_ctrl_pkg::phase_t state_q, state_d;
   logic in_load;     // Any memory load phase
   logic in_run;      // Output sink active
   logic src_ready;   // Both input sources ready to start
   logic load_seen_q; // Beat taken since the last load clear
   logic out_seen_q;  // Same for the output sink

   assign src_ready = a_ready_start_i && b_ready_start_i;
   assign in_load   = state_q inside {panda_ctrl_pkg::load_config, panda_ctrl_pkg::load_instr,
                                      panda_ctrl_pkg::load_lut, panda_ctrl_pkg::load_sparse,
                                      panda_ctrl_pkg::load_act, panda_ctrl_pkg::load_wconv,
                                      panda_ctrl_pkg::load_wfc};
   assign in_run    = (state_q == panda_ctrl_pkg::accel_running);

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         panda_ctrl_pkg::idle:
            if (start_i) state_d = panda_ctrl_pkg::load_config;
         panda_ctrl_pkg::load_config:
            if (load_done_i) state_d = panda_ctrl_pkg::load_instr;
         panda_ctrl_pkg::load_instr:
            if (load_done_i) state_d = panda_ctrl_pkg::load_lut;
         panda_ctrl_pkg::load_lut:
            if (load_done_i) state_d = panda_ctrl_pkg::load_sparse;
         panda_ctrl_pkg::load_sparse:
            if (load_done_i) state_d = panda_ctrl_pkg::load_act;
         panda_ctrl_pkg::load_act: begin
            if (load_done_i) begin // Weight loads depend on the layer type
               unique case (mode_i)
                  panda_ctrl_pkg::mode_cnn: state_d = panda_ctrl_pkg::load_wconv;
                  panda_ctrl_pkg::mode_fc:  state_d = panda_ctrl_pkg::load_wfc;
                  default:                  state_d = panda_ctrl_pkg::accel_run;
               endcase
            end
         end
         panda_ctrl_pkg::load_wconv:
            if (load_done_i) state_d = panda_ctrl_pkg::load_wfc;
         panda_ctrl_pkg::load_wfc:
            if (load_done_i) state_d = panda_ctrl_pkg::accel_run;
         panda_ctrl_pkg::accel_run:
            state_d = panda_ctrl_pkg::accel_running; // Single start cycle
         panda_ctrl_pkg::accel_running:
            if (engine_done_i) state_d = panda_ctrl_pkg::terminate;
         panda_ctrl_pkg::terminate:
            if (src_ready) state_d = panda_ctrl_pkg::idle; // Sources drained
         default: state_d = panda_ctrl_pkg::idle;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q     <= panda_ctrl_pkg::idle;
         load_seen_q <= 1'b0;
         out_seen_q  <= 1'b0;
      end else if (clear_i) begin
         state_q     <= panda_ctrl_pkg::idle; // Abort current job
         load_seen_q <= 1'b0;
         out_seen_q  <= 1'b0;
      end else begin
         state_q     <= state_d;
         load_seen_q <= !load_clear_o && (load_seen_q || stream_ready_o);
         out_seen_q  <= !out_clear_o && (out_seen_q || out_stream_ready_o);
      end
   end

   // Clear outside the active phase and once it completes
   assign load_clear_o = !in_load || load_done_i;
   assign out_clear_o  = !in_run || engine_done_i;

   assign stream_ready_o     = in_load && load_ready_i; // Also memory write enable
   assign out_stream_ready_o = in_run && out_ready_i;

   // Kick the streamers only before the first beat of a phase
   assign a_req_start_o = in_load && src_ready && !load_seen_q && !load_done_i;
   assign b_req_start_o = a_req_start_o;
   assign c_req_start_o = in_run && c_ready_start_i && !out_seen_q && !out_done_i;

   assign engine_clear_o  = (state_q == panda_ctrl_pkg::idle);
   assign engine_enable_o = !(state_q inside {panda_ctrl_pkg::idle, panda_ctrl_pkg::terminate});
   assign engine_start_o  = (state_q == panda_ctrl_pkg::accel_run);
   assign done_o          = (state_q == panda_ctrl_pkg::terminate) && src_ready;
   assign phase_o         = state_q;

   // Engine start is a single-cycle pulse per job
   a_start_pulse : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      engine_start_o |=> !engine_start_o
   );

endmodule

// ==== src/panda_stream_cfg.sv ====
module panda_stream_cfg (
   input  panda_ctrl_pkg::phase_t   phase_i,
   input  panda_ctrl_pkg::word_t    params_i [panda_ctrl_pkg::ParamCount],
   output panda_ctrl_pkg::word_t    trans_size_o,
   output panda_ctrl_pkg::word_t    a_base_addr_o,
   output panda_ctrl_pkg::word_t    b_base_addr_o,
   output panda_ctrl_pkg::word_t    c_base_addr_o,
   output panda_ctrl_pkg::word_t    out_size_o,
   output panda_ctrl_pkg::mem_sel_t mem_sel_o
);

   int unsigned idx;    // Beat-count register of the phase's memory
   logic        active; // Phase loads a memory

   always_comb begin
      idx       = panda_ctrl_pkg::CfgN;
      active    = 1'b1;
      mem_sel_o = panda_ctrl_pkg::sel_null;
      unique case (phase_i)
         panda_ctrl_pkg::load_config: begin
            idx       = panda_ctrl_pkg::CfgN;
            mem_sel_o = panda_ctrl_pkg::sel_config;
         end
         panda_ctrl_pkg::load_instr: begin
            idx       = panda_ctrl_pkg::InstrN;
            mem_sel_o = panda_ctrl_pkg::sel_instr;
         end
         panda_ctrl_pkg::load_lut: begin
            idx       = panda_ctrl_pkg::LutN;
            mem_sel_o = panda_ctrl_pkg::sel_lut;
         end
         panda_ctrl_pkg::load_sparse: begin
            idx       = panda_ctrl_pkg::SparseN;
            mem_sel_o = panda_ctrl_pkg::sel_sparse;
         end
         panda_ctrl_pkg::load_act: begin
            idx       = panda_ctrl_pkg::ActN;
            mem_sel_o = panda_ctrl_pkg::sel_act;
         end
         panda_ctrl_pkg::load_wconv: begin
            idx       = panda_ctrl_pkg::WConvN;
            mem_sel_o = panda_ctrl_pkg::sel_wconv;
         end
         panda_ctrl_pkg::load_wfc: begin
            idx       = panda_ctrl_pkg::WFcN;
            mem_sel_o = panda_ctrl_pkg::sel_wfc;
         end
         default: active = 1'b0; // Idle, run and terminate
      endcase
      // A-stream base follows the count, D-stream base after it
      trans_size_o  = active ? params_i[idx]     : '0;
      a_base_addr_o = active ? params_i[idx + 1] : '0;
      b_base_addr_o = active ? params_i[idx + 2] : '0;
   end

   // Output sink setup does not depend on the phase
   assign out_size_o    = params_i[panda_ctrl_pkg::OutN];
   assign c_base_addr_o = params_i[panda_ctrl_pkg::OutAddr];

endmodule
